/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = raster_tb
FILELIST = verilog.f
OBJDIR   = obj_dir
PASS     = Done: no errors

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "^$(PASS)$$"

clean:
	rm -rf $(OBJDIR)

/* hdl/elastic_buffer.sv */
// two-entry elastic buffer
`timescale 1ns/10ps
module elastic_buffer #(
    parameter int DATAW = 32
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             valid_in,
    output logic             ready_in,
    input  logic [DATAW-1:0] data_in,
    output logic             valid_out,
    input  logic             ready_out,
    output logic [DATAW-1:0] data_out
);
    logic             main_valid;
    logic [DATAW-1:0] main_data;
    logic             skid_valid;
    logic [DATAW-1:0] skid_data;
    logic             push;
    logic             pop;
    logic             main_load;

    // ready only looks at the skid entry, which cuts the path from ready_out
    assign ready_in  = !skid_valid;
    assign valid_out = main_valid;
    assign data_out  = main_data;

    assign push      = valid_in && ready_in;
    assign pop       = main_valid && ready_out;
    assign main_load = pop || !main_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (main_load) begin
            // the skid entry drains first, there is no push while it is full
            main_valid <= skid_valid || push;
            skid_valid <= 1'b0;
        end else if (push) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (main_load) begin
            main_data <= skid_valid ? skid_data : data_in;
        end
        if (push && !main_load) begin
            skid_data <= data_in;
        end
    end

endmodule

/* hdl/raster_agent.sv */
// raster agent
// joins execute requests with stamp batches
`timescale 1ns/10ps
module raster_agent
    import raster_pkg::*;
#(
    parameter int NUM_LANES = 2
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 exe_valid,
    output logic                                 exe_ready,
    input  logic [NW_BITS-1:0]                   exe_wid,
    input  logic [NUM_LANES-1:0]                 exe_tmask,
    input  logic [XLEN-1:0]                      exe_pc,
    input  logic [RD_BITS-1:0]                   exe_rd,
    input  logic                                 req_valid,
    output logic                                 req_ready,
    input  logic [NUM_LANES-1:0][STAMP_BITS-1:0] req_stamps,
    input  logic                                 req_done,
    output logic                                 commit_valid,
    input  logic                                 commit_ready,
    output logic [NW_BITS-1:0]                   commit_wid,
    output logic [NUM_LANES-1:0]                 commit_tmask,
    output logic [XLEN-1:0]                      commit_pc,
    output logic [RD_BITS-1:0]                   commit_rd,
    output logic [NUM_LANES-1:0][XLEN-1:0]       commit_data,
    output logic                                 csr_we,
    output logic [NW_BITS-1:0]                   csr_wr_wid,
    output logic [NUM_LANES-1:0]                 csr_wr_tmask,
    output logic [NUM_LANES-1:0][STAMP_BITS-1:0] csr_wr_stamps
);
    localparam int DATAW = commit_bits(NUM_LANES);

    logic                           rsp_valid;
    logic                           rsp_ready;
    logic [NUM_LANES-1:0][XLEN-1:0] rsp_data;

    // each side is ready only when the other side and the buffer are
    assign exe_ready = req_valid && rsp_ready;
    assign req_ready = exe_valid && rsp_ready;
    assign rsp_valid = exe_valid && req_valid;

    // stamps land in the CSRs on the same edge the join fires
    assign csr_we        = exe_valid && req_valid && rsp_ready;
    assign csr_wr_wid    = exe_wid;
    assign csr_wr_tmask  = exe_tmask;
    assign csr_wr_stamps = req_stamps;

    // bit 0 tells the shader whether more stamps are coming
    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            rsp_data[l] = XLEN'({req_stamps[l][PID_LSB +: PID_BITS], ~req_done});
        end
    end

    elastic_buffer #(
        .DATAW (DATAW)
    ) rsp_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (rsp_valid),
        .ready_in  (rsp_ready),
        .data_in   ({exe_wid, exe_tmask, exe_pc, exe_rd, rsp_data}),
        .valid_out (commit_valid),
        .ready_out (commit_ready),
        .data_out  ({commit_wid, commit_tmask, commit_pc, commit_rd, commit_data})
    );

endmodule

/* hdl/raster_csr.sv */
// raster CSR storage
// one stamp word per warp and lane
`timescale 1ns/10ps
module raster_csr
    import raster_pkg::*;
#(
    parameter int NUM_LANES  = 2,
    localparam int LANE_BITS = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 csr_we,
    input  logic [NW_BITS-1:0]                   csr_wr_wid,
    input  logic [NUM_LANES-1:0]                 csr_wr_tmask,
    input  logic [NUM_LANES-1:0][STAMP_BITS-1:0] csr_wr_stamps,
    input  logic [NW_BITS-1:0]                   csr_rd_wid,
    input  logic [LANE_BITS-1:0]                 csr_rd_lane,
    input  logic [CSR_ADDR_BITS-1:0]             csr_rd_addr,
    output logic [XLEN-1:0]                      csr_rd_data
);
    logic [NUM_LANES-1:0][STAMP_BITS-1:0] stamps [NUM_WARPS];
    logic [STAMP_BITS-1:0]                rd_word;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < NUM_WARPS; w++) begin
                stamps[w] <= '0;
            end
        end else if (csr_we) begin
            // inactive lanes keep whatever stamp they held before
            for (int l = 0; l < NUM_LANES; l++) begin
                if (csr_wr_tmask[l]) begin
                    stamps[csr_wr_wid][l] <= csr_wr_stamps[l];
                end
            end
        end
    end

    assign rd_word = stamps[csr_rd_wid][csr_rd_lane];

    always_comb begin
        case (csr_rd_addr)
            CSR_POS: begin
                csr_rd_data = XLEN'({rd_word[POS_Y_LSB +: POS_BITS],
                                     rd_word[POS_X_LSB +: POS_BITS]});
            end
            CSR_MASK_PID: begin
                csr_rd_data = XLEN'({rd_word[PID_LSB +: PID_BITS],
                                     rd_word[MASK_LSB +: MASK_BITS]});
            end
            default: begin
                csr_rd_data = '0;
            end
        endcase
    end

endmodule

/* hdl/raster_pkg.sv */
// raster unit shared definitions
package raster_pkg;

    // datapath widths
    localparam int XLEN      = 32;
    localparam int POS_BITS  = 10;
    localparam int MASK_BITS = 4;
    localparam int PID_BITS  = 8;
    localparam int RD_BITS   = 5;

    // warp count and warp id width
    localparam int NUM_WARPS = 4;
    localparam int NW_BITS   = 2;

    // the stamp word has pid on top and pos_x at the bottom
    localparam int STAMP_BITS = 32;
    localparam int POS_X_LSB  = 0;
    localparam int POS_Y_LSB  = POS_X_LSB + POS_BITS;
    localparam int MASK_LSB   = POS_Y_LSB + POS_BITS;
    localparam int PID_LSB    = MASK_LSB + MASK_BITS;

    // raster CSR map
    localparam int CSR_ADDR_BITS = 1;

    // pos_y and pos_x of the stamp
    localparam logic [CSR_ADDR_BITS-1:0] CSR_POS = 1'b0;

    // pid and coverage mask of the stamp
    localparam logic [CSR_ADDR_BITS-1:0] CSR_MASK_PID = 1'b1;

    // width of the packed commit payload for a given lane count
    function automatic int commit_bits(input int num_lanes);
        return NW_BITS + num_lanes + XLEN + RD_BITS + num_lanes * XLEN;
    endfunction

endpackage

/* hdl/raster_unit_top.sv */
// raster unit top level
`timescale 1ns/10ps
module raster_unit_top
    import raster_pkg::*;
#(
    parameter int NUM_LANES   = 2,
    parameter int QUEUE_DEPTH = 4,
    localparam int LANE_BITS  = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 stamp_valid,
    output logic                                 stamp_ready,
    input  logic [NUM_LANES-1:0][STAMP_BITS-1:0] stamp_data,
    input  logic                                 stamp_done,
    input  logic                                 exe_valid,
    output logic                                 exe_ready,
    input  logic [NW_BITS-1:0]                   exe_wid,
    input  logic [NUM_LANES-1:0]                 exe_tmask,
    input  logic [XLEN-1:0]                      exe_pc,
    input  logic [RD_BITS-1:0]                   exe_rd,
    output logic                                 commit_valid,
    input  logic                                 commit_ready,
    output logic [NW_BITS-1:0]                   commit_wid,
    output logic [NUM_LANES-1:0]                 commit_tmask,
    output logic [XLEN-1:0]                      commit_pc,
    output logic [RD_BITS-1:0]                   commit_rd,
    output logic [NUM_LANES-1:0][XLEN-1:0]       commit_data,
    input  logic [NW_BITS-1:0]                   csr_rd_wid,
    input  logic [LANE_BITS-1:0]                 csr_rd_lane,
    input  logic [CSR_ADDR_BITS-1:0]             csr_rd_addr,
    output logic [XLEN-1:0]                      csr_rd_data
);
    // queue to agent
    logic                                 req_valid;
    logic                                 req_ready;
    logic [NUM_LANES-1:0][STAMP_BITS-1:0] req_stamps;
    logic                                 req_done;

    // agent to CSR block
    logic                                 csr_we;
    logic [NW_BITS-1:0]                   csr_wr_wid;
    logic [NUM_LANES-1:0]                 csr_wr_tmask;
    logic [NUM_LANES-1:0][STAMP_BITS-1:0] csr_wr_stamps;

    stamp_queue #(
        .NUM_LANES   (NUM_LANES),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) stamp_queue_i (
        .clk, .rst_n, .stamp_valid, .stamp_ready, .stamp_data, .stamp_done,
        .req_valid, .req_ready, .req_stamps, .req_done
    );

    raster_agent #(
        .NUM_LANES (NUM_LANES)
    ) raster_agent_i (
        .clk, .rst_n, .exe_valid, .exe_ready, .exe_wid, .exe_tmask, .exe_pc, .exe_rd,
        .req_valid, .req_ready, .req_stamps, .req_done,
        .commit_valid, .commit_ready, .commit_wid, .commit_tmask, .commit_pc,
        .commit_rd, .commit_data,
        .csr_we, .csr_wr_wid, .csr_wr_tmask, .csr_wr_stamps
    );

    raster_csr #(
        .NUM_LANES (NUM_LANES)
    ) raster_csr_i (
        .clk, .rst_n, .csr_we, .csr_wr_wid, .csr_wr_tmask, .csr_wr_stamps,
        .csr_rd_wid, .csr_rd_lane, .csr_rd_addr, .csr_rd_data
    );

endmodule

/* hdl/stamp_queue.sv */
// stamp batch FIFO
`timescale 1ns/10ps
module stamp_queue
    import raster_pkg::*;
#(
    parameter int NUM_LANES   = 2,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 stamp_valid,
    output logic                                 stamp_ready,
    input  logic [NUM_LANES-1:0][STAMP_BITS-1:0] stamp_data,
    input  logic                                 stamp_done,
    output logic                                 req_valid,
    input  logic                                 req_ready,
    output logic [NUM_LANES-1:0][STAMP_BITS-1:0] req_stamps,
    output logic                                 req_done
);
    localparam int ENTRY_BITS = NUM_LANES * STAMP_BITS + 1;
    localparam int PTR_BITS   = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_BITS   = $clog2(QUEUE_DEPTH + 1);

    logic [ENTRY_BITS-1:0] entries [QUEUE_DEPTH];
    logic [PTR_BITS-1:0]   rd_ptr;
    logic [PTR_BITS-1:0]   wr_ptr;
    logic [CNT_BITS-1:0]   count;
    logic                  push;
    logic                  pop;

    // the pointers wrap explicitly so any depth works
    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        if (ptr == PTR_BITS'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign req_valid = (count != '0);
    // a full queue still accepts when the head leaves in the same cycle
    assign stamp_ready = (count != CNT_BITS'(QUEUE_DEPTH)) || req_ready;
    assign push = stamp_valid && stamp_ready;
    assign pop  = req_valid && req_ready;

    assign {req_stamps, req_done} = entries[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= {stamp_data, stamp_done};
        end
    end

endmodule

/* sim/clock_gen.sv */
// testbench clock and reset
`timescale 1ns/10ps
module clock_gen (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end
endmodule

/* sim/raster_sva.sv */
// raster unit protocol assertions
`timescale 1ns/10ps
module raster_sva
    import raster_pkg::*;
#(
    parameter int NUM_LANES = 2
) (
    input logic                                 clk,
    input logic                                 rst_n,
    input logic                                 stamp_valid,
    input logic                                 stamp_ready,
    input logic                                 exe_valid,
    input logic                                 exe_ready,
    input logic                                 req_valid,
    input logic                                 req_ready,
    input logic [NUM_LANES-1:0][STAMP_BITS-1:0] req_stamps,
    input logic                                 req_done,
    input logic                                 commit_valid,
    input logic                                 commit_ready,
    input logic [XLEN-1:0]                      commit_pc,
    input logic [NUM_LANES-1:0][XLEN-1:0]       commit_data
);
    // the reset values hold on the first edge after release
    reset_state: assert property (@(posedge clk)
        $rose(rst_n) |-> !commit_valid && !exe_ready && stamp_ready)
        else $error("reset state of the handshakes is wrong");

    // the queue head must not move or be overwritten until the agent takes it
    req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && !req_ready |=>
            req_valid && $stable(req_stamps) && $stable(req_done))
        else $error("queue head changed before it was taken");

    commit_hold: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid && !commit_ready |=>
            commit_valid && $stable(commit_data) && $stable(commit_pc))
        else $error("commit changed before it was taken");

    // a stamp into an empty queue with an idle buffer is committed two edges later
    join_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (stamp_valid && stamp_ready && exe_valid && !exe_ready && !commit_valid)
            ##1 exe_valid |=> commit_valid)
        else $error("commit did not follow the stamp within two edges");
endmodule

bind raster_unit_top raster_sva #(.NUM_LANES(NUM_LANES)) raster_sva_i (
    .clk(clk), .rst_n(rst_n), .stamp_valid(stamp_valid), .stamp_ready(stamp_ready),
    .exe_valid(exe_valid), .exe_ready(exe_ready),
    .req_valid(req_valid), .req_ready(req_ready), .req_stamps(req_stamps),
    .req_done(req_done), .commit_valid(commit_valid), .commit_ready(commit_ready),
    .commit_pc(commit_pc), .commit_data(commit_data)
);

/* sim/raster_tb.sv */
// raster unit testbench
`timescale 1ns/10ps
module raster_tb;
    import raster_pkg::*;

    localparam int NUM_LANES   = 2;
    localparam int QUEUE_DEPTH = 4;
    localparam int TIMEOUT     = 300;

    typedef struct packed {
        logic [NW_BITS-1:0]                   wid;
        logic [NUM_LANES-1:0]                 tmask;
        logic [XLEN-1:0]                      pc;
        logic [RD_BITS-1:0]                   rd;
        logic                                 done;
        logic [NUM_LANES-1:0][STAMP_BITS-1:0] stamps;
    } join_t;

    typedef struct packed {
        logic                                 done;
        logic [NUM_LANES-1:0][STAMP_BITS-1:0] stamps;
    } batch_t;

    logic clk, rst_n;
    logic stamp_valid, stamp_ready, stamp_done;
    logic [NUM_LANES-1:0][STAMP_BITS-1:0] stamp_data;
    logic exe_valid, exe_ready;
    logic [NW_BITS-1:0] exe_wid;
    logic [NUM_LANES-1:0] exe_tmask;
    logic [XLEN-1:0] exe_pc;
    logic [RD_BITS-1:0] exe_rd;
    logic commit_valid, commit_ready;
    logic [NW_BITS-1:0] commit_wid;
    logic [NUM_LANES-1:0] commit_tmask;
    logic [XLEN-1:0] commit_pc;
    logic [RD_BITS-1:0] commit_rd;
    logic [NUM_LANES-1:0][XLEN-1:0] commit_data;
    logic [NW_BITS-1:0] csr_rd_wid;
    logic [0:0] csr_rd_lane;
    logic [CSR_ADDR_BITS-1:0] csr_rd_addr;
    logic [XLEN-1:0] csr_rd_data;

    logic [15:0] lfsr = 16'd17268;
    int value_errors = 0;
    int other_errors = 0;
    int ready_mode = 0;
    int occupancy = 0;
    batch_t batch_q[$];
    join_t commit_q[$];
    logic [STAMP_BITS-1:0] csr_model [NUM_WARPS][NUM_LANES];

    clock_gen clock_gen_i (.clk(clk), .rst_n(rst_n));

    raster_unit_top #(
        .NUM_LANES   (NUM_LANES),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) raster_unit_top_i (.*);

    // galois LFSR with taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        assert (exp === act) else begin
            value_errors++;
            $display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            other_errors++;
            $display("Failure at %0t: %s", $time, what);
        end
    endtask

    task automatic report_timeout(input string what);
        other_errors++;
        $display("Timeout at %0t: %s", $time, what);
        $display("Errors: %0d value, %0d other", value_errors, other_errors);
        $display("Done: errors found");
        $finish;
    endtask

    task automatic drive_stamps(input int count, input bit gaps);
        logic [31:0] r;
        int waited;
        for (int i = 0; i < count; i++) begin
            if (gaps) begin
                rand_bits(2, r);
                repeat (r) @(negedge clk);
            end
            for (int l = 0; l < NUM_LANES; l++) begin
                rand_bits(32, r);
                stamp_data[l] = r;
            end
            rand_bits(1, r);
            stamp_done = r[0];
            stamp_valid = 1'b1;
            waited = 0;
            #1;
            while (!stamp_ready) begin
                @(negedge clk);
                #1;
                waited++;
                if (waited > TIMEOUT) report_timeout("stamp batch never accepted");
            end
            @(negedge clk);
            stamp_valid = 1'b0;
        end
    endtask

    task automatic drive_exe(input int count, input bit gaps);
        logic [31:0] r;
        int waited;
        for (int i = 0; i < count; i++) begin
            if (gaps) begin
                rand_bits(2, r);
                repeat (r) @(negedge clk);
            end
            rand_bits(NW_BITS, r);
            exe_wid = r[NW_BITS-1:0];
            rand_bits(NUM_LANES, r);
            exe_tmask = r[NUM_LANES-1:0];
            rand_bits(32, r);
            exe_pc = r;
            rand_bits(RD_BITS, r);
            exe_rd = r[RD_BITS-1:0];
            exe_valid = 1'b1;
            waited = 0;
            #1;
            while (!exe_ready) begin
                @(negedge clk);
                #1;
                waited++;
                if (waited > TIMEOUT) report_timeout("execute request never accepted");
            end
            @(negedge clk);
            exe_valid = 1'b0;
        end
    endtask

    task automatic check_commit();
        join_t e;
        logic [XLEN-1:0] exp_word;
        if (commit_q.size() == 0) begin
            check_true(1'b0, "commit without a pending join");
            return;
        end
        e = commit_q.pop_front();
        check_value("commit_wid", 64'(e.wid), 64'(commit_wid));
        check_value("commit_tmask", 64'(e.tmask), 64'(commit_tmask));
        check_value("commit_pc", 64'(e.pc), 64'(commit_pc));
        check_value("commit_rd", 64'(e.rd), 64'(commit_rd));
        for (int l = 0; l < NUM_LANES; l++) begin
            exp_word = (XLEN'(e.stamps[l][31:24]) << 1) | XLEN'(!e.done);
            check_value($sformatf("commit_data[%0d]", l), 64'(exp_word), 64'(commit_data[l]));
        end
    endtask

    // samples between the falling and the rising edge, where all values are settled
    task automatic monitor();
        logic [31:0] r;
        logic [STAMP_BITS-1:0] w;
        batch_t b;
        join_t j;
        forever begin
            @(negedge clk);
            rand_bits(NW_BITS, r);
            csr_rd_wid = r[NW_BITS-1:0];
            rand_bits(1, r);
            csr_rd_lane = r[0];
            rand_bits(1, r);
            csr_rd_addr = r[0];
            #2;
            w = csr_model[csr_rd_wid][csr_rd_lane];
            if (csr_rd_addr == CSR_POS) begin
                check_value("csr_rd_data", 64'(w[19:0]), 64'(csr_rd_data));
            end else begin
                check_value("csr_rd_data", 64'(w[31:20]), 64'(csr_rd_data));
            end
            if (stamp_valid && !stamp_ready) begin
                check_true(occupancy == QUEUE_DEPTH, "stamp_ready low with room in the queue");
            end
            if (commit_valid && commit_ready) begin
                check_commit();
            end
            if (exe_valid && exe_ready) begin
                if (batch_q.size() == 0) begin
                    check_true(1'b0, "join with no stamp batch queued");
                end else begin
                    b = batch_q.pop_front();
                    j = '{exe_wid, exe_tmask, exe_pc, exe_rd, b.done, b.stamps};
                    commit_q.push_back(j);
                    occupancy--;
                    for (int l = 0; l < NUM_LANES; l++) begin
                        if (exe_tmask[l]) begin
                            csr_model[exe_wid][l] = b.stamps[l];
                        end
                    end
                end
            end
            if (stamp_valid && stamp_ready) begin
                batch_q.push_back('{stamp_done, stamp_data});
                occupancy++;
            end
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (commit_q.size() != 0 || batch_q.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) report_timeout("commits did not drain");
        end
    endtask

    // commit_ready follows the stall mode of the current phase
    initial begin
        logic [31:0] r;
        forever begin
            @(negedge clk);
            if (ready_mode == 1) begin
                rand_bits(1, r);
                commit_ready = r[0];
            end else begin
                commit_ready = (ready_mode == 0);
            end
        end
    end

    initial begin
        int waited;
        stamp_valid = 1'b0;
        stamp_done = 1'b0;
        stamp_data = '0;
        exe_valid = 1'b0;
        exe_wid = '0;
        exe_tmask = '0;
        exe_pc = '0;
        exe_rd = '0;
        commit_ready = 1'b1;
        csr_rd_wid = '0;
        csr_rd_lane = '0;
        csr_rd_addr = '0;
        for (int w = 0; w < NUM_WARPS; w++) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                csr_model[w][l] = '0;
            end
        end
        waited = 0;
        while (rst_n !== 1'b1) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) report_timeout("reset never released");
        end
        #1;
        check_value("commit_valid", 64'(0), 64'(commit_valid));
        check_value("exe_ready", 64'(0), 64'(exe_ready));
        check_value("stamp_ready", 64'(1), 64'(stamp_ready));
        // one CSR entry per cycle, covering every warp, lane and address
        for (int a = 0; a < 16; a++) begin
            @(negedge clk);
            {csr_rd_wid, csr_rd_lane, csr_rd_addr} = a[3:0];
            #2;
            check_value("csr_rd_data", 64'(0), 64'(csr_rd_data));
        end
        fork
            monitor();
        join_none
        @(negedge clk);
        // exe held with commit_ready high gives the two-edge path
        ready_mode = 0;
        fork
            drive_stamps(12, 1'b1);
            drive_exe(12, 1'b0);
        join
        wait_drain();
        // full stall fills the buffer and then the queue
        ready_mode = 2;
        fork
            drive_stamps(10, 1'b0);
            drive_exe(10, 1'b0);
            begin
                repeat (30) @(negedge clk);
                ready_mode = 1;
            end
        join
        wait_drain();
        fork
            drive_stamps(40, 1'b1);
            drive_exe(40, 1'b1);
        join
        wait_drain();
        repeat (4) @(negedge clk);
        $display("Errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end
endmodule

/* verilog.f */
hdl/raster_pkg.sv
hdl/stamp_queue.sv
hdl/raster_csr.sv
hdl/elastic_buffer.sv
hdl/raster_agent.sv
hdl/raster_unit_top.sv
sim/clock_gen.sv
sim/raster_sva.sv
sim/raster_tb.sv
